// File: dcache_subsys.f
+incdir+rtl
rtl/dbus_pkg.sv
rtl/cbus_pkg.sv
rtl/tag_store.sv
rtl/data_ram.sv
rtl/burst_counter.sv
rtl/miss_fsm.sv
rtl/dcache_top.sv
verif/tb_mem.sv
verif/tb_dcache.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_dcache
FILELIST = dcache_subsys.f
OBJ      = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: verif/tb_dcache.sv
module tb_dcache
    import dbus_pkg::*;
    import cbus_pkg::*;
();
    localparam int TIMEOUT = 400;

    logic       clk;
    logic       resetn;
    logic       stall_en;
    dbus_req_t  dbus_req;
    dbus_resp_t dbus_resp;
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;
    int         errors;
    int         tests;
    int         failed;

    dcache_top dut (
        .clk       (clk),
        .resetn    (resetn),
        .dbus_req  (dbus_req),
        .dbus_resp (dbus_resp),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    tb_mem u_mem (
        .clk       (clk),
        .resetn    (resetn),
        .stall_en  (stall_en),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    always #4 clk = ~clk;

    function automatic dbus_addr_t make_addr(tag_t tag, index_t index, offset_t offset);
        return '{tag: tag, index: index, offset: offset, zeros: '0};
    endfunction

    // initial memory content, word address xor marker
    function automatic word_t pattern(dbus_addr_t a);
        logic [31:0] raw;
        raw = a;
        return {2'b00, raw[31:2]} ^ 32'hc0de0000;
    endfunction

    function automatic word_t merge(word_t old, word_t wdata, dbus_wrten_t wen);
        word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (wen[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic report_timeout(string why);
        $display("timeout: %s", why);
        errors++;
    endtask

    task automatic compare_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_line(string name, line_t got, line_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_op(string name, cbus_op_t got, cbus_op_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(string name, int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s failed", name);
            failed++;
        end
    endtask

    // one request, held until addr_ok, finished by data_ok
    task automatic access(input logic is_write, input dbus_wrten_t wen, input dbus_addr_t addr,
                          input word_t wdata, output word_t rdata);
        int cnt;
        @(negedge clk);
        dbus_req = '{valid: 1'b1, is_write: is_write, write_en: wen, addr: addr, data: wdata};
        #1;
        cnt = 0;
        while (!dbus_resp.addr_ok && cnt < TIMEOUT) begin
            @(negedge clk);
            #1;
            cnt++;
        end
        if (!dbus_resp.addr_ok) report_timeout("request never accepted");
        @(negedge clk);
        dbus_req = '0;
        // data_ok belongs to the cycle right after acceptance
        if (!dbus_resp.data_ok) begin
            $display("data_ok did not come one cycle after addr_ok for address %h", addr);
            errors++;
        end
        rdata = dbus_resp.data;
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (cbus_req.valid && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (cbus_req.valid) report_timeout("memory bus stayed busy");
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        compare_word("cbus_req.valid", word_t'(cbus_req.valid), '0);
        compare_word("data_ok", word_t'(dbus_resp.data_ok), '0);
        end_test("reset", e);
    endtask

    task automatic test_read_miss();
        int         e;
        int         reads;
        word_t      rd;
        dbus_addr_t a;
        e = errors;
        reads = u_mem.read_count;
        a = make_addr(26'h3, 2'd0, 2'd2);
        access(1'b0, '0, a, '0, rd);
        compare_word("read miss data", rd, pattern(a));
        wait_idle();
        compare_word("read bursts", word_t'(u_mem.read_count), word_t'(reads + 1));
        compare_op("burst op", u_mem.last_op, CBUS_READ);
        for (int i = 0; i < 4; i++) begin
            compare_word("refill order", word_t'(u_mem.rd_order[i]), word_t'(offset_t'(2 + i)));
        end
        end_test("read miss", e);
    endtask

    task automatic test_read_hits();
        int         e;
        int         reads;
        word_t      rd;
        dbus_addr_t a;
        e = errors;
        reads = u_mem.read_count;
        for (int o = 0; o < 4; o++) begin
            a = make_addr(26'h3, 2'd0, offset_t'(o));
            access(1'b0, '0, a, '0, rd);
            compare_word("hit data", rd, pattern(a));
        end
        compare_word("read bursts", word_t'(u_mem.read_count), word_t'(reads));
        end_test("read hits", e);
    endtask

    task automatic test_write_hit();
        int         e;
        word_t      rd;
        dbus_addr_t a;
        e = errors;
        a = make_addr(26'h3, 2'd0, 2'd1);
        access(1'b1, 4'b0101, a, 32'haabbccdd, rd);
        compare_word("write old word", rd, pattern(a));
        access(1'b0, '0, a, '0, rd);
        compare_word("merged word", rd, merge(pattern(a), 32'haabbccdd, 4'b0101));
        end_test("write hit", e);
    endtask

    task automatic test_evict();
        int         e;
        int         writes;
        word_t      rd;
        word_t      exp;
        dbus_addr_t a;
        dbus_addr_t d;
        e = errors;
        // dirty line goes first, then three more lines fill the set
        a = make_addr(26'h11, 2'd1, 2'd0);
        access(1'b0, '0, a, '0, rd);
        d = make_addr(26'h11, 2'd1, 2'd2);
        access(1'b1, 4'b1100, d, 32'h12345678, rd);
        compare_word("dirty old word", rd, pattern(d));
        wait_idle();
        for (int t = 0; t < 3; t++) begin
            a = make_addr(tag_t'(26'h12 + t), 2'd1, 2'd0);
            access(1'b0, '0, a, '0, rd);
            compare_word("fill data", rd, pattern(a));
            wait_idle();
        end
        writes = u_mem.write_count;
        a = make_addr(26'h15, 2'd1, 2'd1);
        access(1'b0, '0, a, '0, rd);
        compare_word("conflict data", rd, pattern(a));
        wait_idle();
        compare_word("write bursts", word_t'(u_mem.write_count), word_t'(writes + 1));
        compare_op("burst op", u_mem.last_op, CBUS_WRITE);
        compare_line("evicted line", '{valid: 1'b1, dirty: 1'b1, tag: u_mem.wr_addr.tag},
                     '{valid: 1'b1, dirty: 1'b1, tag: 26'h11});
        compare_word("evicted index", word_t'(u_mem.wr_addr.index), 32'd1);
        compare_word("write start", word_t'(u_mem.first_off), 32'd1);
        for (int o = 0; o < 4; o++) begin
            a = make_addr(26'h11, 2'd1, offset_t'(o));
            exp = (o == 2) ? merge(pattern(a), 32'h12345678, 4'b1100) : pattern(a);
            compare_word("written word", u_mem.wr_line[o], exp);
        end
        end_test("evict", e);
    endtask

    task automatic test_stalled_refill();
        int         e;
        word_t      rd;
        dbus_addr_t a;
        e = errors;
        stall_en = 1'b1;
        for (int i = 0; i < 5; i++) begin
            a = make_addr(26'h7, 2'd2, offset_t'(2 + i));
            access(1'b0, '0, a, '0, rd);
            compare_word("stalled read", rd, pattern(a));
        end
        wait_idle();
        stall_en = 1'b0;
        end_test("stalled refill", e);
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b1;
        stall_en = 1'b0;
        dbus_req = '0;
        errors = 0;
        tests = 0;
        failed = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
        test_reset();
        test_read_miss();
        test_read_hits();
        test_write_hit();
        test_evict();
        test_stalled_refill();
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end
endmodule

// File: verif/tb_mem.sv
module tb_mem
    import dbus_pkg::*;
    import cbus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       stall_en,
    input  cbus_req_t  cbus_req,
    output cbus_resp_t cbus_resp
);
    word_t      mem [logic [29:0]];
    int         seed;
    int         beat;
    int         read_count;
    int         write_count;
    cbus_op_t   last_op;
    offset_t    first_off;
    offset_t    rd_order [4];
    word_t      wr_line [4];
    dbus_addr_t wr_addr;

    // untouched words hold their word address xor a marker
    function automatic word_t word_at(logic [29:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {2'b00, a} ^ 32'hc0de0000;
    endfunction

    initial begin
        seed = 32'h52a7;
        beat = 0;
        read_count = 0;
        write_count = 0;
        cbus_resp = '0;
    end

    // response changes on the falling edge, cache samples it on the rising one
    always @(negedge clk) begin
        logic [31:0] r;
        offset_t     off;
        logic [29:0] a;
        cbus_resp.okay = 1'b0;
        cbus_resp.last = 1'b0;
        if (resetn) begin
            beat = 0;
        end else if (cbus_req.valid) begin
            r = $random(seed);
            if (!(stall_en && r[0])) begin
                off = offset_t'(cbus_req.addr.offset + beat);
                a = {cbus_req.addr.tag, cbus_req.addr.index, off};
                if (beat == 0) begin
                    last_op = cbus_req.op;
                    first_off = cbus_req.addr.offset;
                    if (cbus_req.op == CBUS_WRITE) begin
                        write_count++;
                        wr_addr = cbus_req.addr;
                    end else begin
                        read_count++;
                    end
                end
                if (cbus_req.op == CBUS_WRITE) begin
                    mem[a] = cbus_req.wdata;
                    wr_line[off] = cbus_req.wdata;
                end else begin
                    cbus_resp.rdata = word_at(a);
                    rd_order[beat] = off;
                end
                cbus_resp.okay = 1'b1;
                cbus_resp.last = beat == 3;
                beat = (beat == 3) ? 0 : beat + 1;
            end
        end
    end
endmodule

// File: rtl/dcache_top.sv
module dcache_top
    import dbus_pkg::*;
    import cbus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  dbus_req_t  dbus_req,
    output dbus_resp_t dbus_resp,
    output cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp
);
    logic        hit;
    way_t        hit_way;
    way_t        victim_way;
    line_t       victim_line;
    logic        addr_ok;
    logic        accept;
    logic        touch;
    logic        mark_dirty;
    logic        allocate;
    logic        burst_start;
    logic        beat;
    offset_t     offset;
    ready_bits_t ready_bits;
    ram_pos_t    hit_pos;
    ram_pos_t    miss_pos;
    dbus_wrten_t hit_wen;
    dbus_wrten_t refill_en;
    word_t       hit_rdata;
    word_t       old_word;
    logic        data_ok;

    tag_store u_tag_store (
        .clk         (clk),
        .resetn      (resetn),
        .lookup_addr (dbus_req.addr),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_line (victim_line),
        .touch       (touch),
        .mark_dirty  (mark_dirty),
        .allocate    (allocate)
    );

    // port a serves hits, port b the refill and victim reads
    assign hit_pos = '{way: hit_way, index: dbus_req.addr.index, offset: dbus_req.addr.offset};
    assign hit_wen = (accept && dbus_req.is_write) ? dbus_req.write_en : '0;

    data_ram u_data_ram (
        .clk        (clk),
        .write_en_a (hit_wen),
        .pos_a      (hit_pos),
        .wdata_a    (dbus_req.data),
        .rdata_a    (hit_rdata),
        .write_en_b (refill_en),
        .pos_b      (miss_pos),
        .wdata_b    (cbus_resp.rdata),
        .rdata_b    (old_word)
    );

    burst_counter u_burst_counter (
        .clk          (clk),
        .resetn       (resetn),
        .start        (burst_start),
        .start_offset (dbus_req.addr.offset),
        .beat         (beat),
        .offset       (offset),
        .ready_bits   (ready_bits)
    );

    miss_fsm u_miss_fsm (
        .clk         (clk),
        .resetn      (resetn),
        .dbus_req    (dbus_req),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_line (victim_line),
        .offset      (offset),
        .ready_bits  (ready_bits),
        .old_word    (old_word),
        .cbus_resp   (cbus_resp),
        .addr_ok     (addr_ok),
        .accept      (accept),
        .touch       (touch),
        .mark_dirty  (mark_dirty),
        .allocate    (allocate),
        .burst_start (burst_start),
        .beat        (beat),
        .miss_pos    (miss_pos),
        .refill_en   (refill_en),
        .cbus_req    (cbus_req)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= accept;
        end
    end

    assign dbus_resp = '{addr_ok: addr_ok, data_ok: data_ok, data: hit_rdata};
endmodule

// File: rtl/miss_fsm.sv
`include "dcache_consts.svh"

module miss_fsm
    import dbus_pkg::*;
    import cbus_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  dbus_req_t   dbus_req,
    input  logic        hit,
    input  way_t        hit_way,
    input  way_t        victim_way,
    input  line_t       victim_line,
    input  offset_t     offset,
    input  ready_bits_t ready_bits,
    input  word_t       old_word,
    input  cbus_resp_t  cbus_resp,
    output logic        addr_ok,
    output logic        accept,
    output logic        touch,
    output logic        mark_dirty,
    output logic        allocate,
    output logic        burst_start,
    output logic        beat,
    output ram_pos_t    miss_pos,
    output dbus_wrten_t refill_en,
    output cbus_req_t   cbus_req
);
    miss_state_t state;
    dbus_addr_t  miss_addr;
    way_t        miss_way;
    line_t       miss_vline;
    logic        vwrten;
    offset_t     voffset;
    word_t       victim_buf [1 << `DC_OFFSET_BITS];

    logic in_refill;
    logic miss_avail;
    logic start_miss;

    // only the line under refill can have words missing
    assign in_refill = state == MISS_READ && hit_way == miss_way &&
        dbus_req.addr.index == miss_addr.index;
    assign addr_ok = hit && (!in_refill || ready_bits[dbus_req.addr.offset]);
    assign accept = dbus_req.valid && addr_ok;

    // next refill may overlap the last write-back beat
    assign miss_avail = state == MISS_IDLE || (state == MISS_WRITE && cbus_resp.last);
    assign start_miss = dbus_req.valid && !hit && miss_avail;

    assign touch = accept;
    assign mark_dirty = accept && dbus_req.is_write;
    assign allocate = start_miss;
    assign burst_start = start_miss;
    assign beat = cbus_resp.okay && state != MISS_IDLE;

    assign miss_pos = '{way: miss_way, index: miss_addr.index, offset: offset};
    assign refill_en = (state == MISS_READ && cbus_resp.okay) ? '1 : '0;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= MISS_IDLE;
            vwrten <= 1'b0;
        end else begin
            // old word shows up on port b one cycle after the refill write
            vwrten <= state == MISS_READ && cbus_resp.okay;
            case (state)
                MISS_READ: begin
                    if (cbus_resp.last) begin
                        state <= (miss_vline.valid && miss_vline.dirty) ? MISS_WRITE : MISS_IDLE;
                    end
                end
                MISS_WRITE: begin
                    if (cbus_resp.last) begin
                        state <= MISS_IDLE;
                    end
                end
                default: ;
            endcase
            if (start_miss) begin
                state <= MISS_READ;
            end
        end
    end

    always_ff @(posedge clk) begin
        voffset <= offset;
        if (vwrten) begin
            victim_buf[voffset] <= old_word;
        end
        if (start_miss) begin
            miss_addr <= dbus_req.addr;
            miss_way <= victim_way;
            miss_vline <= victim_line;
        end else if (state == MISS_READ && cbus_resp.last) begin
            // write-back goes to the evicted line, same start offset
            miss_addr.tag <= miss_vline.tag;
        end
    end

    assign cbus_req.valid = state != MISS_IDLE;
    assign cbus_req.op = state == MISS_WRITE ? CBUS_WRITE : CBUS_READ;
    assign cbus_req.addr = '{tag: miss_addr.tag, index: miss_addr.index,
                             offset: miss_addr.offset, zeros: '0};
    assign cbus_req.wdata = victim_buf[offset];
endmodule

// File: rtl/burst_counter.sv
module burst_counter
    import dbus_pkg::*;
    import cbus_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        start,
    input  offset_t     start_offset,
    input  logic        beat,
    output offset_t     offset,
    output ready_bits_t ready_bits
);
    always_ff @(posedge clk) begin
        if (resetn) begin
            offset <= '0;
            ready_bits <= '0;
        end else if (start) begin
            offset <= start_offset;
            ready_bits <= '0;
        end else if (beat) begin
            // word at the current offset has just been written
            ready_bits[offset] <= 1'b1;
            // wraps inside the line
            offset <= offset_t'(offset + 1'b1);
        end
    end
endmodule

// File: rtl/data_ram.sv
`include "dcache_consts.svh"

module data_ram
    import dbus_pkg::*;
(
    input  logic        clk,
    input  dbus_wrten_t write_en_a,
    input  ram_pos_t    pos_a,
    input  word_t       wdata_a,
    output word_t       rdata_a,
    input  dbus_wrten_t write_en_b,
    input  ram_pos_t    pos_b,
    input  word_t       wdata_b,
    output word_t       rdata_b
);
    localparam int DEPTH = 1 << (`DC_WAY_BITS + `DC_INDEX_BITS + `DC_OFFSET_BITS);

    word_t mem [DEPTH];

    // read-first on both ports
    // port b hands the evicted word to the victim buffer this way
    always_ff @(posedge clk) begin
        rdata_a <= mem[pos_a];
        rdata_b <= mem[pos_b];
        for (int i = 0; i < `DC_DATA_BYTES; i++) begin
            if (write_en_a[i]) begin
                mem[pos_a][8*i +: 8] <= wdata_a[8*i +: 8];
            end
            if (write_en_b[i]) begin
                mem[pos_b][8*i +: 8] <= wdata_b[8*i +: 8];
            end
        end
    end
endmodule

// File: rtl/tag_store.sv
`include "dcache_consts.svh"

module tag_store
    import dbus_pkg::*;
    import cbus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  dbus_addr_t lookup_addr,
    output logic       hit,
    output way_t       hit_way,
    output way_t       victim_way,
    output line_t      victim_line,
    input  logic       touch,
    input  logic       mark_dirty,
    input  logic       allocate
);
    localparam int NUM_WAYS = 1 << `DC_WAY_BITS;
    localparam int NUM_SETS = 1 << `DC_INDEX_BITS;

    line_t lines [NUM_SETS][NUM_WAYS];
    plru_t plru [NUM_SETS];

    index_t               idx;
    logic [NUM_WAYS-1:0]  hit_bits;
    way_t                 used_way;

    // follow the tree bits down to the least recently used leaf
    function automatic way_t plru_victim(plru_t bits);
        int   node;
        way_t way;
        node = 0;
        way = '0;
        for (int lvl = 0; lvl < `DC_WAY_BITS; lvl++) begin
            way[`DC_WAY_BITS-1-lvl] = bits[node];
            node = 2 * node + 1 + int'(bits[node]);
        end
        return way;
    endfunction

    // point every node on the path away from the used way
    function automatic plru_t plru_update(plru_t bits, way_t way);
        int    node;
        plru_t upd;
        node = 0;
        upd = bits;
        for (int lvl = 0; lvl < `DC_WAY_BITS; lvl++) begin
            upd[node] = ~way[`DC_WAY_BITS-1-lvl];
            node = 2 * node + 1 + int'(way[`DC_WAY_BITS-1-lvl]);
        end
        return upd;
    endfunction

    assign idx = lookup_addr.index;

    // parallel compare of all ways
    always_comb begin
        hit_bits = '0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_bits[w] = lines[idx][w].valid && lines[idx][w].tag == lookup_addr.tag;
            if (hit_bits[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |hit_bits;

    assign victim_way = plru_victim(plru[idx]);
    assign victim_line = lines[idx][victim_way];
    assign used_way = allocate ? victim_way : hit_way;

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    lines[s][w].valid <= 1'b0;
                    lines[s][w].dirty <= 1'b0;
                end
            end
        end else begin
            if (touch || allocate) begin
                plru[idx] <= plru_update(plru[idx], used_way);
            end
            // new line starts clean, refill fills the data behind it
            if (allocate) begin
                lines[idx][victim_way] <= '{valid: 1'b1, dirty: 1'b0, tag: lookup_addr.tag};
            end
            if (mark_dirty) begin
                lines[idx][hit_way].dirty <= 1'b1;
            end
        end
    end
endmodule

// File: rtl/cbus_pkg.sv
`include "dcache_consts.svh"

package cbus_pkg;
    import dbus_pkg::*;

    typedef enum logic {
        CBUS_READ,
        CBUS_WRITE
    } cbus_op_t;

    // addr holds the line base plus the first word of the wrapped burst
    typedef struct packed {
        logic       valid;
        cbus_op_t   op;
        dbus_addr_t addr;
        word_t      wdata;
    } cbus_req_t;

    typedef struct packed {
        logic  okay;
        logic  last;
        word_t rdata;
    } cbus_resp_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_t;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_READ,
        MISS_WRITE
    } miss_state_t;

    // tree nodes in heap order, root at bit 0
    typedef logic [(1 << `DC_WAY_BITS)-2:0] plru_t;
    typedef logic [(1 << `DC_OFFSET_BITS)-1:0] ready_bits_t;
endpackage

// File: rtl/dbus_pkg.sv
`include "dcache_consts.svh"

package dbus_pkg;
    typedef logic [`DC_DATA_WIDTH-1:0] word_t;
    typedef logic [`DC_TAG_BITS-1:0] tag_t;
    typedef logic [`DC_INDEX_BITS-1:0] index_t;
    typedef logic [`DC_OFFSET_BITS-1:0] offset_t;
    typedef logic [`DC_WAY_BITS-1:0] way_t;
    // byte position inside a word, zero on this bus
    typedef logic [$clog2(`DC_DATA_BYTES)-1:0] zeros_t;

    typedef logic [`DC_DATA_BYTES-1:0] dbus_wrten_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
        zeros_t  zeros;
    } dbus_addr_t;

    typedef struct packed {
        logic        valid;
        logic        is_write;
        dbus_wrten_t write_en;
        dbus_addr_t  addr;
        word_t       data;
    } dbus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    // word address inside data_ram
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } ram_pos_t;
endpackage

// File: rtl/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// word geometry
`define DC_DATA_WIDTH 32
`define DC_DATA_BYTES 4

// cache geometry, all as log2
`define DC_WAY_BITS 2
`define DC_INDEX_BITS 2
`define DC_OFFSET_BITS 2

// 32 minus index, offset and byte bits
`define DC_TAG_BITS 26

`endif
